// ==== flist.f ====
verilog/gfPkg.sv
verilog/rsPkg.sv
verilog/gfLogRom.sv
verilog/gfExpRom.sv
verilog/lambdaRootSearch.sv
verilog/rootHandshake.sv
verilog/rsRootFinder.sv
tests/rsRootFinder_sva.sv
tests/rsRootFinderTb.sv

// ==== Makefile ====
TOP = rsRootFinderTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== tests/rsRootFinderTb.sv ====
// testbench for the RS root finder, LFSR-built lambdas checked against a GF(2^8) model
`default_nettype none

module rsRootFinderTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int numPolys = 20;                       // 1 full, 7 partial, 1 empty, 1 edge, 10 random
   localparam int cycleLimit = 1000 * numPolys + 100;
   localparam logic [8:0] modelPoly = 9'h11D;          // x^8 + x^4 + x^3 + x^2 + 1

   logic             clk = 1'b0;
   logic             reset;
   logic             inReq;
   rsPkg::lambdaPoly inPoly;
   logic             inAck;
   logic             outReq;
   rsPkg::rootSet    outRoots;
   logic             outAck;

   logic [15:0]      lfsr = 16'd76;    // seed
   int               cycles = 0;
   gfPkg::gfElem     chosen [8];       // roots of the polynomial being built
   int               numChosen;
   rsPkg::lambdaPoly polyList [numPolys];
   rsPkg::rootSet    expList [numPolys];
   string            nameList [numPolys];

   rsRootFinder dut_i (
      .clk(clk), .reset(reset),
      .inReq(inReq), .inPoly(inPoly), .inAck(inAck),
      .outReq(outReq), .outRoots(outRoots), .outAck(outAck)
   );

   always #50 clk = ~clk;   // 100 ns period

   // run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit)
      begin
         $display("timeout, the DUT gave no result within %0d cycles", cycleLimit);
         $display("TESTBENCH FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   ////////////////////
   // random source and field model

   // 16-bit Fibonacci, taps 16 14 13 11
   function automatic logic [15:0] lfsrStep(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic randBits(input int n, output int unsigned v);
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsrStep(lfsr);   // one step per bit
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // shift-and-reduce multiply
   function automatic gfPkg::gfElem gfMul(input gfPkg::gfElem a, input gfPkg::gfElem b);
      logic [8:0]   p;
      gfPkg::gfElem r;
      r = 8'h00;
      p = {1'b0, a};
      for (int i = 0; i < 8; i++)
      begin
         if (b[i])
            r = r ^ p[7:0];
         p = p << 1;
         if (p[8])
            p = p ^ modelPoly;
      end
      return r;
   endfunction

   function automatic gfPkg::gfElem gfInv(input gfPkg::gfElem a);
      gfPkg::gfElem r;
      r = 8'h00;
      for (int b = 1; b < 256; b++)
         if (gfMul(a, 8'(b)) == 8'h01)
            r = 8'(b);
      return r;
   endfunction

   task automatic checkValue(input string name, input logic [71:0] expected,
                             input logic [71:0] actual);
      if (expected !== actual)
      begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // appends n distinct nonzero roots
   task automatic addRandomRoots(input int n);
      int unsigned  v;
      gfPkg::gfElem r;
      logic         dup;
      for (int k = 0; k < n; k++)
      begin
         do
         begin
            randBits(8, v);
            r = 8'(v);
            dup = (r == 8'h00);
            for (int i = 0; i < numChosen; i++)
               if (chosen[i] == r)
                  dup = 1'b1;
         end
         while (dup);
         chosen[numChosen] = r;
         numChosen++;
      end
   endtask

   // lambda = prod(1 + x/r), then a full sweep gives the expected roots
   task automatic buildCase(input int idx, input string name);
      gfPkg::gfElem c [9];
      gfPkg::gfElem inv;
      gfPkg::gfElem val;
      logic [255:0] mask;
      logic [63:0]  wantSlots;
      logic [63:0]  gotSlots;
      logic [71:0]  coefBits;
      int           found;
      int           j;
      c = '{default: 8'h00};
      c[0] = 8'h01;               // L0 = 1
      mask = '0;
      for (int k = 0; k < numChosen; k++)
      begin
         inv = gfInv(chosen[k]);
         for (int i = 8; i > 0; i--)
            c[i] = c[i] ^ gfMul(inv, c[i - 1]);   // descending, old c[i-1] still there
         mask[chosen[k]] = 1'b1;
      end
      found = 0;
      j = 0;
      wantSlots = '0;
      gotSlots = '0;
      for (int x = 1; x < 256; x++)
      begin
         if (mask[x])
         begin
            wantSlots[63 - 8 * j -: 8] = 8'(x);   // ascending by construction
            j++;
         end
         val = c[8];
         for (int i = 7; i >= 0; i--)
            val = gfMul(val, 8'(x)) ^ c[i];       // Horner
         if (val == 8'h00)
         begin
            if (found < 8)
               gotSlots[63 - 8 * found -: 8] = 8'(x);
            found++;
         end
      end
      checkValue({name, " model count"}, 72'(numChosen), 72'(found));
      checkValue({name, " model roots"}, 72'(wantSlots), 72'(gotSlots));
      coefBits = '0;
      for (int i = 0; i < 9; i++)
         coefBits = {coefBits[63:0], c[i]};       // coef0 ends up on top
      polyList[idx] = rsPkg::lambdaPoly'(coefBits);
      expList[idx] = rsPkg::rootSet'({4'(found), gotSlots});
      nameList[idx] = name;
   endtask

   ////////////////////
   // input channel

   task automatic offerInput(input int idx);
      inPoly = polyList[idx];
      inReq = 1'b1;
   endtask

   task automatic finishInput();
      while (!inAck)
         @(negedge clk);
      inReq = 1'b0;
      while (inAck)
         @(negedge clk);
   endtask

   ////////////////////
   // main sequence

   initial
   begin
      int unsigned   v;
      rsPkg::rootSet held;
      reset = 1'b1;
      inReq = 1'b0;
      inPoly = '0;
      outAck = 1'b0;

      numChosen = 0;
      addRandomRoots(8);
      buildCase(0, "full degree");
      for (int i = 1; i < 8; i++)
      begin
         numChosen = 0;
         addRandomRoots(i);
         buildCase(i, $sformatf("partial degree %0d", i));
      end
      numChosen = 0;
      buildCase(8, "no roots");                  // lambda = 1
      chosen[0] = 8'h01;                         // first and last candidates
      chosen[1] = 8'hFF;
      numChosen = 2;
      addRandomRoots(2);
      buildCase(9, "edge elements");
      for (int i = 10; i < numPolys; i++)
      begin
         numChosen = 0;
         randBits(4, v);
         addRandomRoots(int'(v % 32'd9));
         buildCase(i, $sformatf("random %0d", i));
      end

      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      checkValue("reset inAck", 72'(0), 72'(inAck));
      checkValue("reset outReq", 72'(0), 72'(outReq));

      offerInput(0);
      finishInput();
      for (int k = 0; k < numPolys; k++)
      begin
         while (!outReq)
            @(negedge clk);
         checkValue(nameList[k], 72'(expList[k]), 72'(outRoots));
         held = outRoots;
         if (k + 1 < numPolys)
            offerInput(k + 1);                   // queued behind the open result
         randBits(4, v);
         repeat (v)
         begin
            @(negedge clk);
            checkValue("held result", 72'({1'b1, held}), 72'({outReq, outRoots}));
            checkValue("inAck under back-pressure", 72'(0), 72'(inAck));
         end
         outAck = 1'b1;
         while (outReq)
         begin
            @(negedge clk);
            checkValue("inAck before result closed", 72'(0), 72'(inAck));
         end
         randBits(2, v);
         repeat (v + 1)                          // ack still high after req fell
         begin
            @(negedge clk);
            checkValue("inAck while outAck high", 72'(0), 72'(inAck));
         end
         outAck = 1'b0;
         if (k + 1 < numPolys)
            finishInput();
      end

      repeat (4) @(negedge clk);
      if (dut_i.handshake_i.hsChecks_i.violations == 0)
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
      else
      begin
         $display("handshake assertions failed %0d times", dut_i.handshake_i.hsChecks_i.violations);
         $display("TESTBENCH FAILED");
         $fatal(1, "handshake assertion failures");
      end
   end

endmodule

`default_nettype wire

// ==== tests/rsRootFinder_sva.sv ====
// four-phase handshake assertions, bound into every rootHandshake instance
`default_nettype none

module rsRootFinderChecks (
   input wire logic clk,
   input wire logic reset,
   input wire logic inReq,
   input wire logic inAck,
   input wire logic outReq,
   input wire logic outAck,
   input wire logic start
);

   timeunit 1ns;
   timeprecision 100ps;

   int violations = 0;   // failed checks so far

   ////////////////////
   // input channel

   // ack answers a request seen the cycle before
   ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
      $rose(inAck) |-> $past(inReq))
      else
      begin
         violations = violations + 1;
         $error("inAck rose without inReq");
      end

   ////////////////////
   // output channel

   reqHeld: assert property (@(posedge clk) disable iff (reset)
      outReq && !outAck |=> outReq)   // no withdrawal before ack
      else
      begin
         violations = violations + 1;
         $error("outReq dropped before outAck");
      end

   // one search at a time
   noStartWhilePresenting: assert property (@(posedge clk) disable iff (reset)
      start |-> !outReq)
      else
      begin
         violations = violations + 1;
         $error("start pulsed while a result was pending");
      end

endmodule

bind rootHandshake rsRootFinderChecks hsChecks_i (
   .clk(clk), .reset(reset),
   .inReq(inReq), .inAck(inAck),
   .outReq(outReq), .outAck(outAck),
   .start(start)
);

`default_nettype wire

// ==== verilog/rsRootFinder.sv ====
// top level of the RS error-locator root finder, connects handshake, search and both ROMs
`default_nettype none

module rsRootFinder #(
   parameter logic [8:0] fieldPoly = gfPkg::defaultFieldPoly
) (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             inReq,
   input  wire rsPkg::lambdaPoly inPoly,
   output logic                  inAck,
   output logic                  outReq,
   output rsPkg::rootSet         outRoots,
   input  wire logic             outAck
);

   logic             start;
   logic             done;
   rsPkg::lambdaPoly coefs;
   rsPkg::rootSet    roots;
   gfPkg::gfElem     logAddr;
   gfPkg::gfLog      logData;
   gfPkg::gfLog      expAddr0;
   gfPkg::gfLog      expAddr1;
   gfPkg::gfLog      expAddr2;
   gfPkg::gfElem     expData0;
   gfPkg::gfElem     expData1;
   gfPkg::gfElem     expData2;

   rootHandshake handshake_i (
      .clk(clk), .reset(reset),
      .inReq(inReq), .inPoly(inPoly), .inAck(inAck),
      .outReq(outReq), .outRoots(outRoots), .outAck(outAck),
      .start(start), .coefs(coefs), .done(done), .roots(roots)
   );

   lambdaRootSearch search_i (
      .clk(clk), .reset(reset), .start(start), .coefs(coefs),
      .done(done), .roots(roots),
      .logAddr(logAddr), .logData(logData),
      .expAddr0(expAddr0), .expAddr1(expAddr1), .expAddr2(expAddr2),
      .expData0(expData0), .expData1(expData1), .expData2(expData2)
   );

   gfLogRom #(.fieldPoly(fieldPoly)) logRom_i (
      .clk(clk), .addr(logAddr), .data(logData)
   );

   gfExpRom #(.fieldPoly(fieldPoly)) expRom_i (
      .clk(clk),
      .addr0(expAddr0), .addr1(expAddr1), .addr2(expAddr2),
      .data0(expData0), .data1(expData1), .data2(expData2)
   );

endmodule

`default_nettype wire

// ==== verilog/rootHandshake.sv ====
// four-phase req/ack wrapper around the root search, one polynomial in flight at a time
`default_nettype none

module rootHandshake (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             inReq,
   input  wire rsPkg::lambdaPoly inPoly,     // stable while inReq high
   output logic                  inAck,
   output logic                  outReq,
   output rsPkg::rootSet         outRoots,   // held until outAck
   input  wire logic             outAck,
   output logic                  start,      // one-cycle pulse to the search
   output rsPkg::lambdaPoly      coefs,
   input  wire logic             done,
   input  wire rsPkg::rootSet    roots
);

   typedef enum logic [1:0] {hsIdle, hsSearching, hsPresenting, hsClosing} hsState;

   hsState state;
   logic   accept;    // new polynomial taken this cycle
   logic   present;   // result taken this cycle

   // previous input exchange must be fully closed (inAck low) before a new one
   assign accept  = (state == hsIdle) && inReq && !inAck;
   assign present = (state == hsSearching) && done;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state  <= hsIdle;
         inAck  <= 1'b0;
         outReq <= 1'b0;
         start  <= 1'b0;
      end
      else
      begin
         start <= accept;
         if (accept)
            inAck <= 1'b1;
         else if (inAck && !inReq)
            inAck <= 1'b0;                   // source dropped req, close input side
         case (state)
            hsIdle:
               if (accept)
                  state <= hsSearching;
            hsSearching:
               if (done)
               begin
                  outReq <= 1'b1;
                  state  <= hsPresenting;
               end
            hsPresenting:
               if (outAck)
               begin
                  outReq <= 1'b0;
                  state  <= hsClosing;
               end
            default:
               if (!outAck)
                  state <= hsIdle;           // sink released ack
         endcase
      end
   end

   // payload registers
   always_ff @(posedge clk)
   begin
      if (accept)
         coefs <= inPoly;
      if (present)
         outRoots <= roots;
   end

endmodule

`default_nettype wire

// ==== verilog/lambdaRootSearch.sv ====
// lambda root search, converts L1..L8 to logs, then tests all 256 candidates three terms a cycle
`default_nettype none

module lambdaRootSearch (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             start,      // one-cycle pulse, coefs valid
   input  wire rsPkg::lambdaPoly coefs,
   output logic                  done,       // one-cycle pulse, roots final
   output rsPkg::rootSet         roots,
   output gfPkg::gfElem          logAddr,    // to log ROM
   input  wire gfPkg::gfLog      logData,    // one cycle after logAddr
   output gfPkg::gfLog           expAddr0,   // to antilog ROM
   output gfPkg::gfLog           expAddr1,
   output gfPkg::gfLog           expAddr2,
   input  wire gfPkg::gfElem     expData0,   // one cycle after expAddr
   input  wire gfPkg::gfElem     expData1,
   input  wire gfPkg::gfElem     expData2
);

   typedef enum logic [1:0] {sIdle, sLoad, sScan} searchState;

   // travels with each candidate slot down the pipeline
   typedef struct packed {
      logic         warm;    // warm-up flag, set only for slots of the running scan
      gfPkg::gfElem cand;    // candidate element
      logic [1:0]   phase;   // term group: 1-2, 3-5, 6-8
   } slotTag;

   searchState   state;
   logic [3:0]   loadCnt;
   gfPkg::gfElem pending [7];     // L2..L8 queued for the log ROM
   gfPkg::gfLog  logL [1:8];      // coefficient logs
   gfPkg::gfElem lambda0;         // constant term, kept in element form
   gfPkg::gfElem scanCand;
   logic [1:0]   scanPhase;
   slotTag       tagPipe [8];     // index = stage

   gfPkg::gfLog  logX;            // log of the candidate in stage 2
   logic [11:0]  stepX [3];       // x, 2x, 3x, unreduced
   logic [11:0]  groupBase;       // 0, 2x or 5x
   gfPkg::gfLog  termCoef [3];
   logic [11:0]  termRaw [3];
   logic [2:0]   termZero;
   logic [11:0]  termRawQ [3];
   logic [2:0]   termZeroQ;
   logic [8:0]   foldQ [3];       // after first end-around fold
   logic [2:0]   foldZeroQ;
   gfPkg::gfLog  expAddrQ [3];
   gfPkg::gfElem termSum;
   gfPkg::gfElem acc;             // partial sum of the current candidate
   logic         rootHit;

   // 4096 == 16 mod 255, so fold bits 11:8 back onto the low byte
   function automatic logic [8:0] foldHigh(input logic [11:0] s);
      return {5'd0, s[11:8]} + {1'b0, s[7:0]};
   endfunction

   // second fold, then 255 back to 0 so the result never hits the sentinel
   function automatic gfPkg::gfLog foldLow(input logic [8:0] s);
      gfPkg::gfLog r;
      r = s[7:0] + {7'd0, s[8]};
      return (&r) ? 8'h00 : r;
   endfunction

   ////////////////////
   // sequencing: load, candidate slots, tag pipe

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state     <= sIdle;
         loadCnt   <= '0;
         scanCand  <= '0;
         scanPhase <= '0;
         logAddr   <= '0;
         for (int i = 0; i < 8; i++)
            tagPipe[i] <= '0;
      end
      else
      begin
         for (int i = 1; i < 8; i++)
            tagPipe[i] <= tagPipe[i - 1];
         tagPipe[0] <= '0;                     // bubble unless scanning
         case (state)
            sIdle:
            begin
               if (start)
               begin
                  state   <= sLoad;
                  loadCnt <= 4'd1;
                  logAddr <= coefs.coef1;     // L1 first
               end
            end
            sLoad:
            begin
               loadCnt <= loadCnt + 4'd1;
               if (loadCnt < 4'd8)
                  logAddr <= pending[0];      // L2..L8
               if (loadCnt == 4'd9)           // log L8 arrives now
               begin
                  state     <= sScan;
                  scanCand  <= '0;
                  scanPhase <= '0;
               end
            end
            default:
            begin
               tagPipe[0] <= slotTag'{warm: 1'b1, cand: scanCand, phase: scanPhase};
               if (scanPhase == 2'd0)
                  logAddr <= scanCand;        // log x, once per candidate
               if (scanPhase == 2'd2)
               begin
                  scanPhase <= 2'd0;
                  scanCand  <= scanCand + 8'd1;
                  if (&scanCand)
                     state <= sIdle;          // last slot issued, pipe drains
               end
               else
                  scanPhase <= scanPhase + 2'd1;
            end
         endcase
      end
   end

   // coefficient capture and log collection
   always_ff @(posedge clk)
   begin
      if (state == sIdle && start)
      begin
         lambda0 <= coefs.coef0;
         pending <= '{coefs.coef2, coefs.coef3, coefs.coef4, coefs.coef5,
                      coefs.coef6, coefs.coef7, coefs.coef8};
      end
      else if (state == sLoad)
      begin
         for (int i = 0; i < 6; i++)
            pending[i] <= pending[i + 1];
         if (loadCnt >= 4'd2)                 // logs of L1..L8 in order
         begin
            logL[8] <= logData;
            for (int i = 1; i < 8; i++)
               logL[i] <= logL[i + 1];
         end
      end
   end

   ////////////////////
   // term logs, i*log(x) + log(Li)

   always_comb
   begin
      stepX[0] = {4'd0, logX};
      stepX[1] = stepX[0] << 1;
      stepX[2] = stepX[1] + stepX[0];
      case (tagPipe[2].phase)
         2'd0:
         begin
            groupBase = '0;
            termCoef  = '{logL[1], logL[2], gfPkg::logZero};   // third slot unused
         end
         2'd1:
         begin
            groupBase = stepX[1];
            termCoef  = '{logL[3], logL[4], logL[5]};
         end
         default:
         begin
            groupBase = stepX[1] + stepX[2];
            termCoef  = '{logL[6], logL[7], logL[8]};
         end
      endcase
      for (int k = 0; k < 3; k++)
      begin
         termRaw[k]  = {4'd0, termCoef[k]} + groupBase + stepX[k];
         termZero[k] = (termCoef[k] == gfPkg::logZero) || (logX == gfPkg::logZero);
      end
   end

   // pipeline stages 2..7, payload only
   always_ff @(posedge clk)
   begin
      if (tagPipe[1].phase == 2'd0)
         logX <= logData;                     // held over the three groups
      termRawQ  <= termRaw;
      termZeroQ <= termZero;
      for (int k = 0; k < 3; k++)
         foldQ[k] <= foldHigh(termRawQ[k]);
      foldZeroQ <= termZeroQ;
      acc <= ((tagPipe[6].phase == 2'd0) ? lambda0 : acc) ^ termSum;   // restart on L0
   end

   // antilog addresses, sentinel for zero terms
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         expAddrQ <= '{default: '0};
      else
         for (int k = 0; k < 3; k++)
            expAddrQ[k] <= foldZeroQ[k] ? gfPkg::logZero : foldLow(foldQ[k]);
   end

   assign expAddr0 = expAddrQ[0];
   assign expAddr1 = expAddrQ[1];
   assign expAddr2 = expAddrQ[2];
   assign termSum  = expData0 ^ expData1 ^ expData2;

   ////////////////////
   // root capture

   assign rootHit = tagPipe[7].warm && (tagPipe[7].phase == 2'd2) && (acc == '0);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         done  <= 1'b0;
         roots <= '0;
      end
      else
      begin
         done <= tagPipe[7].warm && (tagPipe[7].phase == 2'd2) && (&tagPipe[7].cand);
         if (state == sIdle && start)
            roots <= '0;
         else if (rootHit && roots.count < 4'd8)   // scan order keeps them ascending
         begin
            roots.count <= roots.count + 4'd1;
            case (roots.count)
               4'd0:    roots.root1 <= tagPipe[7].cand;
               4'd1:    roots.root2 <= tagPipe[7].cand;
               4'd2:    roots.root3 <= tagPipe[7].cand;
               4'd3:    roots.root4 <= tagPipe[7].cand;
               4'd4:    roots.root5 <= tagPipe[7].cand;
               4'd5:    roots.root6 <= tagPipe[7].cand;
               4'd6:    roots.root7 <= tagPipe[7].cand;
               default: roots.root8 <= tagPipe[7].cand;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/gfExpRom.sv ====
// log-to-element lookup ROM with three registered read ports, table built at elaboration
`default_nettype none

module gfExpRom #(
   parameter logic [8:0] fieldPoly = gfPkg::defaultFieldPoly
) (
   input  wire logic        clk,
   input  wire gfPkg::gfLog addr0,
   input  wire gfPkg::gfLog addr1,
   input  wire gfPkg::gfLog addr2,
   output gfPkg::gfElem     data0,   // all three valid the cycle after the address
   output gfPkg::gfElem     data1,
   output gfPkg::gfElem     data2
);

   gfPkg::gfElem expTable [gfPkg::fieldSize];

   ////////////////////
   // table fill

   initial
   begin : fillTable
      logic [8:0] walk;
      walk = 9'd1;
      for (int i = 0; i < gfPkg::fieldSize - 1; i++)
      begin
         expTable[i] = walk[7:0];       // alpha^i
         walk = walk << 1;
         if (walk[8])
            walk = walk ^ fieldPoly;
      end
      // sentinel entry, a flagged zero term reads back as 0
      // and drops out of the XOR sum
      expTable[gfPkg::logZero] = '0;
   end

   ////////////////////
   // read ports

   // one term per port, three terms per cycle
   always_ff @(posedge clk)
   begin
      data0 <= expTable[addr0];
      data1 <= expTable[addr1];
      data2 <= expTable[addr2];
   end

endmodule

`default_nettype wire

// ==== verilog/gfLogRom.sv ====
// element-to-log lookup ROM, table built at elaboration from fieldPoly, one-cycle registered read
`default_nettype none

module gfLogRom #(
   parameter logic [8:0] fieldPoly = gfPkg::defaultFieldPoly
) (
   input  wire logic         clk,
   input  wire gfPkg::gfElem addr,   // element, 0 allowed
   output gfPkg::gfLog       data    // valid the cycle after addr
);

   gfPkg::gfLog logTable [gfPkg::fieldSize];

   ////////////////////
   // table fill

   // walk alpha^0 .. alpha^254 and record each exponent at its element
   initial
   begin : fillTable
      logic [8:0] walk;
      walk = 9'd1;                      // alpha^0
      logTable[0] = gfPkg::logZero;     // zero has no log
      for (int i = 0; i < gfPkg::fieldSize - 1; i++)
      begin
         logTable[walk[7:0]] = gfPkg::gfLog'(i);
         walk = walk << 1;              // times alpha
         if (walk[8])
            walk = walk ^ fieldPoly;    // reduce, clears bit 8
      end
   end

   ////////////////////
   // read port

   always_ff @(posedge clk)
   begin
      data <= logTable[addr];
   end

endmodule

`default_nettype wire

// ==== verilog/rsPkg.sv ====
// decoder-level bundles exchanged between the handshake wrapper and the root search
`default_nettype none

package rsPkg;

   // error locator polynomial, coef0 is the constant term (1 for a normal lambda)
   typedef struct packed {
      gfPkg::gfElem coef0;
      gfPkg::gfElem coef1;
      gfPkg::gfElem coef2;
      gfPkg::gfElem coef3;
      gfPkg::gfElem coef4;
      gfPkg::gfElem coef5;
      gfPkg::gfElem coef6;
      gfPkg::gfElem coef7;
      gfPkg::gfElem coef8;
   } lambdaPoly;

   // roots in ascending order, slots past count stay 0
   typedef struct packed {
      logic [3:0]   count;   // 0..8
      gfPkg::gfElem root1;
      gfPkg::gfElem root2;
      gfPkg::gfElem root3;
      gfPkg::gfElem root4;
      gfPkg::gfElem root5;
      gfPkg::gfElem root6;
      gfPkg::gfElem root7;
      gfPkg::gfElem root8;
   } rootSet;

endpackage

`default_nettype wire

// ==== verilog/gfPkg.sv ====
// GF(2^8) element and log types plus field constants, shared by the ROMs and the root search
`default_nettype none

package gfPkg;

   ////////////////////
   // field types

   typedef logic [7:0] gfElem;   // polynomial form, bit i is the alpha^i coefficient
   typedef logic [7:0] gfLog;    // power of alpha, 0..254 for nonzero elements

   ////////////////////
   // field constants

   // number of field elements incl. zero, also the depth of both ROMs
   localparam int fieldSize = 256;

   // log of element 0, never a real power since alpha^255 == alpha^0
   // the antilog ROM maps this address back to element 0
   localparam gfLog logZero = 8'hFF;

   // x^8 + x^4 + x^3 + x^2 + 1, primitive, the usual RS(255,k) choice
   localparam logic [8:0] defaultFieldPoly = 9'h11D;

endpackage

`default_nettype wire
